//--- design/idu_pkg.sv
package idu_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef logic [31:0]       inst_t;
    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // rv32i major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // operation handed to the execute stage
    typedef enum logic [4:0] {
        OP_NONE,
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR,
        OP_OR, OP_AND, OP_SLL, OP_SRL, OP_SRA,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR
    } alu_op_e;

    // result in flight from alu or lsu
    typedef struct packed {
        logic      vld;
        logic      ld;
        reg_addr_t addr;
        word_t     data;
    } fwd_port_t;

    // register file write this cycle
    typedef struct packed {
        logic      vld;
        reg_addr_t addr;
        word_t     data;
    } rf_wb_t;

    // bundle sent to the alu
    typedef struct packed {
        alu_op_e   op;
        word_t     src1;
        word_t     src2;
        word_t     br_st_imm;
        word_t     pc;
        logic      wb_vld;
        reg_addr_t wb_addr;
    } issue_t;

endpackage

//--- design/inst_decoder.sv
module inst_decoder (
    input  idu_pkg::inst_t     ins_i,
    output idu_pkg::alu_op_e   op_o,
    output idu_pkg::reg_addr_t rs1_addr_o,
    output idu_pkg::reg_addr_t rs2_addr_o,
    output idu_pkg::reg_addr_t rd_addr_o,
    output logic               rs1_used_o,
    output logic               rs2_used_o,
    output logic               src2_imm_o,
    output logic               wb_vld_o
);
    import idu_pkg::*;

    opcode_e    opc;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       r_type;
    logic       i_type;
    logic       s_type;
    logic       b_type;
    logic       u_type;
    logic       j_type;

    assign opc    = opcode_e'(ins_i[6:0]);
    assign funct3 = ins_i[14:12];
    assign funct7 = ins_i[31:25];

    assign rs1_addr_o = ins_i[19:15];
    assign rs2_addr_o = ins_i[24:20];
    assign rd_addr_o  = ins_i[11:7];

    // instruction formats
    assign r_type = (opc == OPC_OP);
    assign i_type = (opc == OPC_OP_IMM) | (opc == OPC_LOAD) | (opc == OPC_JALR);
    assign s_type = (opc == OPC_STORE);
    assign b_type = (opc == OPC_BRANCH);
    assign u_type = (opc == OPC_LUI) | (opc == OPC_AUIPC);
    assign j_type = (opc == OPC_JAL);

    assign rs1_used_o = ~(u_type | j_type);
    assign rs2_used_o = r_type | s_type | b_type;
    assign src2_imm_o = i_type | u_type | j_type;
    assign wb_vld_o   = r_type | i_type | u_type | j_type;

    always_comb begin
        op_o = OP_NONE;
        case (opc)
            OPC_OP: begin
                if (funct7 == 7'h00) begin
                    case (funct3)
                        3'd0: op_o = OP_ADD;
                        3'd1: op_o = OP_SLL;
                        3'd2: op_o = OP_SLT;
                        3'd3: op_o = OP_SLTU;
                        3'd4: op_o = OP_XOR;
                        3'd5: op_o = OP_SRL;
                        3'd6: op_o = OP_OR;
                        default: op_o = OP_AND;
                    endcase
                end else if (funct7 == 7'h20) begin
                    case (funct3)
                        3'd0: op_o = OP_SUB;
                        3'd5: op_o = OP_SRA;
                        default: op_o = OP_NONE;
                    endcase
                end
            end
            OPC_OP_IMM: begin
                // no subi, shifts still check funct7
                case (funct3)
                    3'd0: op_o = OP_ADD;
                    3'd1: begin
                        if (funct7 == 7'h00) begin
                            op_o = OP_SLL;
                        end
                    end
                    3'd2: op_o = OP_SLT;
                    3'd3: op_o = OP_SLTU;
                    3'd4: op_o = OP_XOR;
                    3'd5: begin
                        if (funct7 == 7'h00) begin
                            op_o = OP_SRL;
                        end else if (funct7 == 7'h20) begin
                            op_o = OP_SRA;
                        end
                    end
                    3'd6: op_o = OP_OR;
                    default: op_o = OP_AND;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'd0: op_o = OP_BEQ;
                    3'd1: op_o = OP_BNE;
                    3'd4: op_o = OP_BLT;
                    3'd5: op_o = OP_BGE;
                    3'd6: op_o = OP_BLTU;
                    3'd7: op_o = OP_BGEU;
                    default: op_o = OP_NONE;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'd0: op_o = OP_LB;
                    3'd1: op_o = OP_LH;
                    3'd2: op_o = OP_LW;
                    3'd4: op_o = OP_LBU;
                    3'd5: op_o = OP_LHU;
                    default: op_o = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'd0: op_o = OP_SB;
                    3'd1: op_o = OP_SH;
                    3'd2: op_o = OP_SW;
                    default: op_o = OP_NONE;
                endcase
            end
            OPC_LUI:   op_o = OP_LUI;
            OPC_AUIPC: op_o = OP_AUIPC;
            OPC_JAL:   op_o = OP_JAL;
            OPC_JALR:  op_o = OP_JALR;
            default:   op_o = OP_NONE;
        endcase
    end

endmodule

//--- design/imm_gen.sv
module imm_gen (
    input  idu_pkg::inst_t ins_i,
    output idu_pkg::word_t imm_o,
    output idu_pkg::word_t br_st_imm_o
);
    import idu_pkg::*;

    opcode_e opc;
    word_t   i_imm;
    word_t   s_imm;
    word_t   b_imm;
    word_t   u_imm;
    word_t   j_imm;

    assign opc = opcode_e'(ins_i[6:0]);

    assign i_imm = {{(XLEN-12){ins_i[31]}}, ins_i[31:20]};
    assign s_imm = {{(XLEN-12){ins_i[31]}}, ins_i[31:25], ins_i[11:7]};
    // b and j keep bit 0 clear
    assign b_imm = {{(XLEN-12){ins_i[31]}}, ins_i[7], ins_i[30:25], ins_i[11:8], 1'b0};
    assign u_imm = {ins_i[31:12], 12'b0};
    assign j_imm = {{(XLEN-20){ins_i[31]}}, ins_i[19:12], ins_i[20], ins_i[30:21], 1'b0};

    always_comb begin
        case (opc)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: imm_o = i_imm;
            OPC_STORE:                      imm_o = s_imm;
            OPC_BRANCH:                     imm_o = b_imm;
            OPC_LUI, OPC_AUIPC:             imm_o = u_imm;
            OPC_JAL:                        imm_o = j_imm;
            default:                        imm_o = '0;
        endcase
    end

    // offset for the alu, separate from src2
    assign br_st_imm_o = (opc == OPC_BRANCH) ? b_imm :
                         (opc == OPC_STORE)  ? s_imm : '0;

endmodule

//--- design/operand_bypass.sv
module operand_bypass (
    input  idu_pkg::reg_addr_t rs_addr_i,
    input  logic               rs_used_i,
    input  idu_pkg::word_t     rf_data_i,
    input  idu_pkg::fwd_port_t alu_fwd_i,
    input  idu_pkg::fwd_port_t lsu_fwd_i,
    input  idu_pkg::rf_wb_t    rf_wb_i,
    output idu_pkg::word_t     data_o,
    output logic               ld_hazard_o
);

    logic alu_hit;
    logic lsu_hit;
    logic wb_hit;

    assign alu_hit = rs_used_i & alu_fwd_i.vld & (alu_fwd_i.addr == rs_addr_i);
    assign lsu_hit = rs_used_i & lsu_fwd_i.vld & (lsu_fwd_i.addr == rs_addr_i);
    assign wb_hit  = rs_used_i & rf_wb_i.vld & (rf_wb_i.addr == rs_addr_i);

    // youngest result wins
    always_comb begin
        if (alu_hit && !alu_fwd_i.ld) begin
            data_o = alu_fwd_i.data;
        end else if (lsu_hit && !lsu_fwd_i.ld) begin
            data_o = lsu_fwd_i.data;
        end else if (wb_hit) begin
            data_o = rf_wb_i.data;
        end else begin
            data_o = rf_data_i;
        end
    end

    // load data not back yet, must wait
    assign ld_hazard_o = (alu_hit & alu_fwd_i.ld) | (lsu_hit & lsu_fwd_i.ld);

endmodule

//--- design/issue_reg.sv
module issue_reg (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               ifu_vld_i,
    input  logic               flush_i,
    input  logic               alu_rdy_i,
    input  logic               hazard_i,
    input  idu_pkg::alu_op_e   op_i,
    input  idu_pkg::word_t     src1_i,
    input  idu_pkg::word_t     src2_i,
    input  idu_pkg::word_t     imm_i,
    input  logic               src2_imm_i,
    input  idu_pkg::word_t     br_st_imm_i,
    input  idu_pkg::word_t     pc_i,
    input  logic               wb_vld_i,
    input  idu_pkg::reg_addr_t wb_addr_i,
    output logic               ifu_rdy_o,
    output logic               issue_vld_o,
    output idu_pkg::issue_t    issue_o
);
    import idu_pkg::*;

    logic  capture;
    word_t src2_sel;

    // slot frees up this cycle or is already empty
    assign ifu_rdy_o = (~issue_vld_o | alu_rdy_i) & ~hazard_i;
    assign capture   = ifu_vld_i & ifu_rdy_o & ~flush_i;

    assign src2_sel = src2_imm_i ? imm_i : src2_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            issue_vld_o <= 1'b0;
        end else if (capture) begin
            issue_vld_o <= 1'b1;
        end else if (alu_rdy_i) begin
            issue_vld_o <= 1'b0;
        end
    end

    // payload held until the next capture
    always_ff @(posedge clk) begin
        if (capture) begin
            issue_o.op        <= op_i;
            issue_o.src1      <= src1_i;
            issue_o.src2      <= src2_sel;
            issue_o.br_st_imm <= br_st_imm_i;
            issue_o.pc        <= pc_i;
            issue_o.wb_vld    <= wb_vld_i;
            issue_o.wb_addr   <= wb_addr_i;
        end
    end

endmodule

//--- design/idu_top.sv
module idu_top (
    input  logic               clk,
    input  logic               reset_i,
    // fetch
    input  logic               ifu_vld_i,
    input  idu_pkg::inst_t     ifu_ins_i,
    input  idu_pkg::word_t     ifu_pc_i,
    output logic               ifu_rdy_o,
    input  logic               flush_i,
    // register file
    output idu_pkg::reg_addr_t rf_rs1_addr_o,
    output idu_pkg::reg_addr_t rf_rs2_addr_o,
    input  idu_pkg::word_t     rf_rs1_data_i,
    input  idu_pkg::word_t     rf_rs2_data_i,
    // bypass sources
    input  idu_pkg::fwd_port_t alu_fwd_i,
    input  idu_pkg::fwd_port_t lsu_fwd_i,
    input  idu_pkg::rf_wb_t    rf_wb_i,
    // alu
    input  logic               alu_rdy_i,
    output logic               issue_vld_o,
    output idu_pkg::issue_t    issue_o
);
    import idu_pkg::*;

    alu_op_e   op;
    reg_addr_t rd_addr;
    logic      rs1_used;
    logic      rs2_used;
    logic      src2_imm;
    logic      wb_vld;
    word_t     imm;
    word_t     br_st_imm;
    word_t     src1_data;
    word_t     src2_data;
    logic      rs1_ld_hazard;
    logic      rs2_ld_hazard;
    logic      hazard;

    inst_decoder u_decoder (
        .ins_i      (ifu_ins_i),
        .op_o       (op),
        .rs1_addr_o (rf_rs1_addr_o),
        .rs2_addr_o (rf_rs2_addr_o),
        .rd_addr_o  (rd_addr),
        .rs1_used_o (rs1_used),
        .rs2_used_o (rs2_used),
        .src2_imm_o (src2_imm),
        .wb_vld_o   (wb_vld)
    );

    imm_gen u_imm_gen (
        .ins_i       (ifu_ins_i),
        .imm_o       (imm),
        .br_st_imm_o (br_st_imm)
    );

    operand_bypass u_bypass_rs1 (
        .rs_addr_i   (rf_rs1_addr_o),
        .rs_used_i   (rs1_used),
        .rf_data_i   (rf_rs1_data_i),
        .alu_fwd_i   (alu_fwd_i),
        .lsu_fwd_i   (lsu_fwd_i),
        .rf_wb_i     (rf_wb_i),
        .data_o      (src1_data),
        .ld_hazard_o (rs1_ld_hazard)
    );

    operand_bypass u_bypass_rs2 (
        .rs_addr_i   (rf_rs2_addr_o),
        .rs_used_i   (rs2_used),
        .rf_data_i   (rf_rs2_data_i),
        .alu_fwd_i   (alu_fwd_i),
        .lsu_fwd_i   (lsu_fwd_i),
        .rf_wb_i     (rf_wb_i),
        .data_o      (src2_data),
        .ld_hazard_o (rs2_ld_hazard)
    );

    assign hazard = rs1_ld_hazard | rs2_ld_hazard;

    issue_reg u_issue_reg (
        .clk         (clk),
        .reset_i     (reset_i),
        .ifu_vld_i   (ifu_vld_i),
        .flush_i     (flush_i),
        .alu_rdy_i   (alu_rdy_i),
        .hazard_i    (hazard),
        .op_i        (op),
        .src1_i      (src1_data),
        .src2_i      (src2_data),
        .imm_i       (imm),
        .src2_imm_i  (src2_imm),
        .br_st_imm_i (br_st_imm),
        .pc_i        (ifu_pc_i),
        .wb_vld_i    (wb_vld),
        .wb_addr_i   (rd_addr),
        .ifu_rdy_o   (ifu_rdy_o),
        .issue_vld_o (issue_vld_o),
        .issue_o     (issue_o)
    );

endmodule

//--- sim/idu_checker.sv
module idu_checker (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               ifu_vld_i,
    input  idu_pkg::inst_t     ifu_ins_i,
    input  logic               ifu_rdy_o,
    input  logic               flush_i,
    input  idu_pkg::fwd_port_t alu_fwd_i,
    input  idu_pkg::fwd_port_t lsu_fwd_i,
    input  logic               alu_rdy_i,
    input  logic               issue_vld_o,
    input  idu_pkg::issue_t    issue_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import idu_pkg::*;

    int unsigned fail_cnt = 0;
    logic        load_hazard;

    // port holds a load for a source the instruction reads
    function automatic logic blocks(fwd_port_t p, inst_t ins);
        logic rs1_rd;
        logic rs2_rd;
        rs1_rd = !(ins[6:0] inside {7'h37, 7'h17, 7'h6f});
        rs2_rd = ins[6:0] inside {7'h33, 7'h23, 7'h63};
        return p.vld && p.ld && ((rs1_rd && p.addr == ins[19:15]) ||
                                 (rs2_rd && p.addr == ins[24:20]));
    endfunction

    assign load_hazard = blocks(alu_fwd_i, ifu_ins_i) || blocks(lsu_fwd_i, ifu_ins_i);

    a_reset_clears: assert property (@(posedge clk) reset_i |=> !issue_vld_o)
        else begin
            fail_cnt++;
            $error("issue_vld_o not low after reset");
        end

    a_hold_stable: assert property (@(posedge clk) disable iff (reset_i)
        issue_vld_o && !alu_rdy_i |=> issue_vld_o && $stable(issue_o))
        else begin
            fail_cnt++;
            $error("issue bundle changed while the alu was stalled");
        end

    a_capture_valid: assert property (@(posedge clk) disable iff (reset_i)
        ifu_vld_i && ifu_rdy_o && !flush_i |=> issue_vld_o)
        else begin
            fail_cnt++;
            $error("accepted instruction not followed by issue_vld_o");
        end

    a_hazard_stall: assert property (@(posedge clk) disable iff (reset_i)
        load_hazard |-> !ifu_rdy_o)
        else begin
            fail_cnt++;
            $error("ifu_rdy_o high during a load-use hazard");
        end

endmodule

//--- sim/tb_idu_top.sv
module tb_idu_top;
    timeunit 1ns;
    timeprecision 100ps;
    import idu_pkg::*;

    localparam int TEST_CYCLES = 16 + 24 + 28 + 16 + 4 * 6 + 40 * 3 + 8 * 4 + 6 * 3;
    localparam int TIMEOUT     = 4 * TEST_CYCLES;

    localparam alu_op_e ARITH_OPS [8] = '{OP_ADD, OP_SLL, OP_SLT, OP_SLTU,
                                          OP_XOR, OP_SRL, OP_OR, OP_AND};
    localparam alu_op_e BRANCH_OPS [8] = '{OP_BEQ, OP_BNE, OP_NONE, OP_NONE,
                                           OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    localparam alu_op_e LOAD_OPS [8] = '{OP_LB, OP_LH, OP_LW, OP_NONE,
                                         OP_LBU, OP_LHU, OP_NONE, OP_NONE};
    localparam alu_op_e STORE_OPS [8] = '{OP_SB, OP_SH, OP_SW, OP_NONE,
                                          OP_NONE, OP_NONE, OP_NONE, OP_NONE};
    localparam logic [6:0] FMT_OPCODES [7] = '{7'h03, 7'h67, 7'h23, 7'h63,
                                               7'h37, 7'h17, 7'h6f};
    localparam logic [6:0] ALL_OPCODES [9] = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h63,
                                               7'h37, 7'h17, 7'h6f, 7'h67};

    logic      clk = 1'b0;
    logic      reset_i;
    logic      ifu_vld_i;
    inst_t     ifu_ins_i;
    word_t     ifu_pc_i;
    logic      ifu_rdy_o;
    logic      flush_i;
    reg_addr_t rf_rs1_addr_o;
    reg_addr_t rf_rs2_addr_o;
    word_t     rf_rs1_data_i;
    word_t     rf_rs2_data_i;
    fwd_port_t alu_fwd_i;
    fwd_port_t lsu_fwd_i;
    rf_wb_t    rf_wb_i;
    logic      alu_rdy_i;
    logic      issue_vld_o;
    issue_t    issue_o;

    logic [31:0] lfsr = 32'h9e6f;
    issue_t      exp_q[$];
    word_t       pc = 32'h0000_1000;
    logic        accepted = 1'b0;
    logic        rdy_random = 1'b0;
    int          checks = 0;
    int          errors = 0;
    int          test_base = 0;
    int          cycles = 0;

    always #2 clk = ~clk;

    idu_top DUT (.*);

    bind idu_top idu_checker u_checker (
        .clk         (clk),
        .reset_i     (reset_i),
        .ifu_vld_i   (ifu_vld_i),
        .ifu_ins_i   (ifu_ins_i),
        .ifu_rdy_o   (ifu_rdy_o),
        .flush_i     (flush_i),
        .alu_fwd_i   (alu_fwd_i),
        .lsu_fwd_i   (lsu_fwd_i),
        .alu_rdy_i   (alu_rdy_i),
        .issue_vld_o (issue_vld_o),
        .issue_o     (issue_o)
    );

    // register file model
    function automatic word_t rf_value(reg_addr_t a);
        return {24'hA5A5A5, 3'b000, a};
    endfunction

    assign rf_rs1_data_i = rf_value(rf_rs1_addr_o);
    assign rf_rs2_data_i = rf_value(rf_rs2_addr_o);

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic byte fmt_of(inst_t ins);
        case (ins[6:0])
            7'h33:               return "R";
            7'h13, 7'h03, 7'h67: return "I";
            7'h23:               return "S";
            7'h63:               return "B";
            7'h37, 7'h17:        return "U";
            7'h6f:               return "J";
            default:             return "-";
        endcase
    endfunction

    // immediate fields gathered in order, then sign extended
    function automatic word_t imm_of(inst_t ins, byte f);
        case (f)
            "I": return 32'($signed(ins[31:20]));
            "S": return 32'($signed({ins[31:25], ins[11:7]}));
            "B": return 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
            "U": return ins & 32'hFFFF_F000;
            "J": return 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
            default: return '0;
        endcase
    endfunction

    function automatic alu_op_e exp_op(inst_t ins);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = ins[14:12];
        f7 = ins[31:25];
        case (ins[6:0])
            7'h33: begin
                if (f7 == 7'h00) return ARITH_OPS[f3];
                if (f7 == 7'h20 && f3 == 3'd0) return OP_SUB;
                if (f7 == 7'h20 && f3 == 3'd5) return OP_SRA;
                return OP_NONE;
            end
            7'h13: begin
                // only the shifts look at funct7
                if (f3 == 3'd5 && f7 == 7'h20) return OP_SRA;
                if ((f3 == 3'd1 || f3 == 3'd5) && f7 != 7'h00) return OP_NONE;
                return ARITH_OPS[f3];
            end
            7'h63:   return BRANCH_OPS[f3];
            7'h03:   return LOAD_OPS[f3];
            7'h23:   return STORE_OPS[f3];
            7'h37:   return OP_LUI;
            7'h17:   return OP_AUIPC;
            7'h6f:   return OP_JAL;
            7'h67:   return OP_JALR;
            default: return OP_NONE;
        endcase
    endfunction

    // alu, then lsu, then write-back, then register file
    function automatic word_t operand(reg_addr_t a, logic used, word_t rf);
        if (!used) return rf;
        if (alu_fwd_i.vld && !alu_fwd_i.ld && alu_fwd_i.addr == a) return alu_fwd_i.data;
        if (lsu_fwd_i.vld && !lsu_fwd_i.ld && lsu_fwd_i.addr == a) return lsu_fwd_i.data;
        if (rf_wb_i.vld && rf_wb_i.addr == a) return rf_wb_i.data;
        return rf;
    endfunction

    function automatic logic load_blocked(fwd_port_t p, inst_t ins);
        byte f;
        f = fmt_of(ins);
        return p.vld && p.ld &&
               ((f != "U" && f != "J" && p.addr == ins[19:15]) ||
                (f inside {"R", "S", "B"} && p.addr == ins[24:20]));
    endfunction

    function automatic issue_t expected_bundle(inst_t ins);
        issue_t b;
        byte    f;
        f = fmt_of(ins);
        b.op = exp_op(ins);
        b.src1 = operand(ins[19:15], f != "U" && f != "J", rf_value(ins[19:15]));
        if (f inside {"I", "U", "J"}) begin
            b.src2 = imm_of(ins, f);
        end else begin
            b.src2 = operand(ins[24:20], f inside {"R", "S", "B"}, rf_value(ins[24:20]));
        end
        b.br_st_imm = (f == "B" || f == "S") ? imm_of(ins, f) : '0;
        b.pc = ifu_pc_i;
        b.wb_vld = f inside {"R", "I", "U", "J"};
        b.wb_addr = ins[11:7];
        return b;
    endfunction

    task automatic expect_word(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic expect_true(logic cond, string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error: %s", what);
        end
    endtask

    task automatic compare_bundle(issue_t exp);
        expect_word("issue_o.op", 32'(issue_o.op), 32'(exp.op));
        expect_word("issue_o.src1", issue_o.src1, exp.src1);
        expect_word("issue_o.src2", issue_o.src2, exp.src2);
        expect_word("issue_o.br_st_imm", issue_o.br_st_imm, exp.br_st_imm);
        expect_word("issue_o.pc", issue_o.pc, exp.pc);
        expect_word("issue_o.wb_vld", 32'(issue_o.wb_vld), 32'(exp.wb_vld));
        expect_word("issue_o.wb_addr", 32'(issue_o.wb_addr), 32'(exp.wb_addr));
    endtask

    // predict what the next rising edge does
    task automatic check_cycle();
        logic hz;
        logic full;
        hz = load_blocked(alu_fwd_i, ifu_ins_i) || load_blocked(lsu_fwd_i, ifu_ins_i);
        full = exp_q.size() != 0;
        expect_word("issue_vld_o", 32'(issue_vld_o), 32'(full));
        expect_word("ifu_rdy_o", 32'(ifu_rdy_o), 32'((!full || alu_rdy_i) && !hz));
        if (full && alu_rdy_i) begin
            compare_bundle(exp_q.pop_front());
        end
        accepted = ifu_vld_i && ifu_rdy_o && !flush_i;
        if (accepted) exp_q.push_back(expected_bundle(ifu_ins_i));
    endtask

    task automatic tick();
        logic [31:0] r;
        if (rdy_random) begin
            r = rand_bits(1);
            alu_rdy_i = r[0];
        end
        #1;
        check_cycle();
        @(negedge clk);
    endtask

    task automatic present(inst_t ins);
        ifu_vld_i = 1'b1;
        ifu_ins_i = ins;
        ifu_pc_i = pc;
        do begin
            tick();
        end while (!accepted);
        pc = pc + 4;
        ifu_vld_i = 1'b0;
    endtask

    task automatic end_test(string name);
        int errs;
        ifu_vld_i = 1'b0;
        flush_i = 1'b0;
        rdy_random = 1'b0;
        alu_rdy_i = 1'b1;
        repeat (3) tick();
        errs = errors + int'(DUT.u_checker.fail_cnt) - test_base;
        $display("test %s finished: %s, %0d errors", name, errs == 0 ? "ok" : "FAILED", errs);
        test_base = errors + int'(DUT.u_checker.fail_cnt);
    endtask

    task automatic decode_alu_ops();
        logic [31:0] r;
        for (int n = 0; n < 24; n++) begin
            r = rand_bits(26);
            if (n % 2 == 0) present({(r[25] ? 7'h20 : 7'h00), r[17:0], 7'h33});
            else present({r[24:0], 7'h13});
        end
        end_test("alu_ops");
    endtask

    task automatic sweep_formats();
        logic [31:0] r;
        for (int n = 0; n < 28; n++) begin
            r = rand_bits(25);
            present({r[24:0], FMT_OPCODES[n % 7]});
        end
        end_test("formats");
    endtask

    function automatic fwd_port_t random_port(inst_t ins);
        fwd_port_t   p;
        logic [31:0] r;
        r = rand_bits(2);
        p.vld = r[1];
        p.ld = 1'b0;
        p.addr = r[0] ? ins[19:15] : ins[24:20];
        p.data = rand_bits(32);
        return p;
    endfunction

    task automatic mix_bypass_ports();
        logic [31:0] r;
        inst_t       ins;
        fwd_port_t   wb;
        for (int n = 0; n < 16; n++) begin
            r = rand_bits(18);
            ins = {7'h00, r[17:0], 7'h33};
            alu_fwd_i = random_port(ins);
            lsu_fwd_i = random_port(ins);
            wb = random_port(ins);
            rf_wb_i = {wb.vld, wb.addr, wb.data};
            present(ins);
        end
        alu_fwd_i = '0;
        lsu_fwd_i = '0;
        rf_wb_i = '0;
        end_test("bypass");
    endtask

    task automatic stall_on_load();
        logic [31:0] r;
        inst_t       ins;
        fwd_port_t   p;
        for (int n = 0; n < 4; n++) begin
            r = rand_bits(18);
            ins = {7'h00, r[17:0], 7'h33};
            p = '0;
            p.vld = 1'b1;
            p.ld = 1'b1;
            p.addr = (n % 2 == 1) ? ins[24:20] : ins[19:15];
            if (n < 2) alu_fwd_i = p;
            else lsu_fwd_i = p;
            ifu_vld_i = 1'b1;
            ifu_ins_i = ins;
            ifu_pc_i = pc;
            repeat (4) begin
                tick();
                expect_true(!accepted, "instruction accepted while its load was pending");
            end
            alu_fwd_i = '0;
            lsu_fwd_i = '0;
            present(ins);
        end
        end_test("load_hazard");
    endtask

    task automatic throttle_alu();
        logic [31:0] r;
        int          k;
        rdy_random = 1'b1;
        for (int n = 0; n < 40; n++) begin
            r = rand_bits(29);
            k = int'(r[28:25]) % 9;
            present({r[24:0], ALL_OPCODES[k]});
        end
        end_test("backpressure");
    endtask

    task automatic flush_fetch();
        logic [31:0] r;
        rdy_random = 1'b1;
        for (int n = 0; n < 8; n++) begin
            r = rand_bits(25);
            ifu_vld_i = 1'b1;
            ifu_ins_i = {r[24:0], 7'h13};
            ifu_pc_i = ~pc;
            flush_i = 1'b1;
            repeat (2) begin
                tick();
                expect_true(!(issue_vld_o && issue_o.pc == ~pc),
                            "flushed instruction reached the issue slot");
            end
            flush_i = 1'b0;
            present({r[24:0], 7'h33});
        end
        end_test("flush");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        int total;
        reset_i = 1'b1;
        ifu_vld_i = 1'b0;
        ifu_ins_i = '0;
        ifu_pc_i = '0;
        flush_i = 1'b0;
        alu_fwd_i = '0;
        lsu_fwd_i = '0;
        rf_wb_i = '0;
        alu_rdy_i = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        decode_alu_ops();
        sweep_formats();
        mix_bypass_ports();
        stall_on_load();
        throttle_alu();
        flush_fetch();
        total = errors + int'(DUT.u_checker.fail_cnt);
        $display("checks %0d, errors %0d", checks, total);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- compile.f
design/idu_pkg.sv
design/inst_decoder.sv
design/imm_gen.sv
design/operand_bypass.sv
design/issue_reg.sv
design/idu_top.sv
sim/idu_checker.sv
sim/tb_idu_top.sv

//--- run.sh
#!/bin/sh
# build, run, then look for the pass line in the log
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_idu_top -f compile.f -o tb_idu_top > build.log 2>&1 &&
./obj_dir/tb_idu_top +verilator+error+limit+100 > sim.log 2>&1
grep -qx "Regression passed" sim.log && echo "simulation passed" || {
    echo "simulation failed, see build.log and sim.log"
    exit 1
}
